//--- design/adpcmb_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared constants, bus types and step table of the ADPCM-B core
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package adpcmb_pkg;

    localparam int          FIFO_DEPTH  = 16;        // code bytes
    localparam logic [1:0]  ADDR_CODES  = 2'd0;
    localparam logic [1:0]  ADDR_DELTA  = 2'd1;
    localparam logic [1:0]  ADDR_STATUS = 2'd2;
    localparam logic [15:0] STEP_MIN    = 16'd127;
    localparam logic [15:0] STEP_MAX    = 16'd24576;
    localparam logic [15:0] STEP_INIT   = 16'd127;
    localparam int          DIV_CYCLES  = 17;        // start to quotient valid

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [1:0]  adr;
        logic [15:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [15:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic [7:0] pad;                             // ignored on code writes
        logic [3:0] hi;                              // played first
        logic [3:0] lo;
    } code_pair_t;

    // write data seen as codes at ADDR_CODES, as rate word at ADDR_DELTA
    typedef union packed {
        code_pair_t  codes;
        logic [15:0] delta_n;
    } wb_wdata_u;

    typedef struct packed {
        logic               valid;                   // one clock per new sample
        logic signed [15:0] value;
    } pcm_sample_t;

    // step multipliers in 64ths, indexed by nibble magnitude
    localparam logic [7:0] step_mult [8] = '{8'd57, 8'd57, 8'd57, 8'd57,
                                             8'd77, 8'd102, 8'd128, 8'd153};

endpackage

//--- design/adpcmb_wb_buffer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// wishbone slave holding the code byte FIFO, delta-N and status
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module adpcmb_wb_buffer (
    input  logic                clk,
    input  logic                reset,
    input  adpcmb_pkg::wb_req_t req,
    output adpcmb_pkg::wb_rsp_t rsp,
    input  logic                pop,
    input  logic                underrun_set,
    output logic [7:0]          head,
    output logic                empty,
    output logic [15:0]         delta_n
);
    import adpcmb_pkg::*;

    logic [7:0]                    mem [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
    logic [$clog2(FIFO_DEPTH):0]   count;           // 0..16
    logic                          full;
    logic                          underrun;        // sticky until status read
    logic                          ack;
    logic [15:0]                   rdata;
    logic                          request;
    logic                          code_wr;
    logic                          accept;
    logic                          push;
    logic                          status_rd;
    wb_wdata_u                     wdata;

    assign wdata     = req.dat;
    assign full      = (count == FIFO_DEPTH);
    assign empty     = (count == '0);
    assign head      = mem[rd_ptr];
    assign request   = req.cyc & req.stb & ~ack;     // ~ack keeps ack to one clock
    assign code_wr   = req.we && (req.adr == ADDR_CODES);
    assign accept    = request & ~(code_wr & full); // back-pressure while full
    assign push      = accept & code_wr;
    assign status_rd = accept & ~req.we & (req.adr == ADDR_STATUS);

    always_ff @(posedge clk) begin
        if (reset) begin
            ack      <= 1'b0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            delta_n  <= '0;
            underrun <= 1'b0;
        end else begin
            ack <= accept;
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;             // none, or push and pop together
            endcase
            if (accept && req.we && req.adr == ADDR_DELTA) delta_n <= wdata.delta_n;
            if (underrun_set) underrun <= 1'b1;      // a new underrun beats the clear
            else if (status_rd) underrun <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= {wdata.codes.hi, wdata.codes.lo};
        if (accept && !req.we) begin
            case (req.adr)
                ADDR_CODES:  rdata <= {8'd0, head};
                ADDR_DELTA:  rdata <= delta_n;
                ADDR_STATUS: rdata <= {7'd0, underrun, 3'd0, count};
                default:     rdata <= '0;
            endcase
        end
    end

    assign rsp.ack = ack;
    assign rsp.dat = rdata;

endmodule

//--- design/adpcmb_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// phase accumulator and ADPCM-B nibble decode, one sample per carry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module adpcmb_decoder (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    sample_en,
    input  logic [7:0]              head,
    input  logic                    empty,
    input  logic [15:0]             delta_n,
    output logic                    pop,
    output logic                    underrun_set,
    output adpcmb_pkg::pcm_sample_t sample
);
    import adpcmb_pkg::*;

    logic [15:0]        acc;                         // phase accumulator
    logic [16:0]        acc_sum;
    logic               advance;
    logic               nib_sel;                     // 0 high nibble, 1 low nibble
    logic [3:0]         nibble;
    logic signed [15:0] smp;
    logic               smp_valid;
    logic [15:0]        step;
    logic [19:0]        diff_prod;
    logic [16:0]        diff;
    logic signed [17:0] smp_next;
    logic signed [15:0] smp_sat;
    logic [21:0]        step_prod;
    logic [15:0]        step_scaled;
    logic [15:0]        step_next;

    assign acc_sum = {1'b0, acc} + {1'b0, delta_n};
    assign advance = sample_en & acc_sum[16];        // carry out means next sample
    assign nibble  = nib_sel ? head[3:0] : head[7:4];

    always_comb begin
        // difference = (2*mag + 1) * step / 8
        diff_prod = 20'({nibble[2:0], 1'b1}) * 20'(step);
        diff      = diff_prod[19:3];                 // at most 46080
        if (nibble[3]) smp_next = {{2{smp[15]}}, smp} - {1'b0, diff};
        else smp_next = {{2{smp[15]}}, smp} + {1'b0, diff};
        if (smp_next > 18'sd32767) smp_sat = 16'sh7fff;
        else if (smp_next < -18'sd32768) smp_sat = 16'sh8000;
        else smp_sat = smp_next[15:0];
    end

    always_comb begin
        step_prod   = 22'(step) * 22'(step_mult[nibble[2:0]]);
        step_scaled = step_prod[21:6];               // divide by 64
        if (step_scaled < STEP_MIN) step_next = STEP_MIN;
        else if (step_scaled > STEP_MAX) step_next = STEP_MAX;
        else step_next = step_scaled;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            acc          <= '0;
            nib_sel      <= 1'b0;
            smp          <= '0;
            smp_valid    <= 1'b0;
            step         <= STEP_INIT;
            pop          <= 1'b0;
            underrun_set <= 1'b0;
        end else begin
            smp_valid    <= 1'b0;                    // pulses default low
            pop          <= 1'b0;
            underrun_set <= 1'b0;
            if (sample_en) acc <= acc_sum[15:0];
            if (advance) begin
                if (empty) begin
                    underrun_set <= 1'b1;            // hold sample and step
                end else begin
                    smp       <= smp_sat;
                    step      <= step_next;
                    smp_valid <= 1'b1;
                    nib_sel   <= ~nib_sel;
                    pop       <= nib_sel;            // byte done after low nibble
                end
            end
        end
    end

    assign sample.valid = smp_valid;
    assign sample.value = smp;

endmodule

//--- design/adpcmb_divider.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// unsigned restoring divider, one quotient bit per clock after start
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module adpcmb_divider (
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    input  logic [15:0] dividend,
    input  logic [15:0] divisor,
    output logic [15:0] quotient
);
    import adpcmb_pkg::*;

    logic [$clog2(DIV_CYCLES+1)-1:0] cnt;            // clocks left, 0 when idle
    logic [15:0]                     q_shift;        // dividend in, quotient out
    logic [15:0]                     div_r;
    logic [16:0]                     rem;
    logic [16:0]                     rem_shift;
    logic [16:0]                     trial;

    assign rem_shift = {rem[15:0], q_shift[15]};
    assign trial     = rem_shift - {1'b0, div_r};   // bit 16 set means no fit

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt      <= '0;
            quotient <= '0;
        end else if (start) begin
            cnt <= ($clog2(DIV_CYCLES+1))'(DIV_CYCLES);
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
            if (cnt == 1) quotient <= (div_r == '0) ? 16'd0 : q_shift;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            q_shift <= dividend;
            div_r   <= divisor;
            rem     <= '0;
        end else if (cnt > 1) begin                  // 16 shift-subtract steps
            rem     <= trial[16] ? rem_shift : trial;
            q_shift <= {q_shift[14:0], ~trial[16]};
        end
    end

endmodule

//--- design/adpcmb_interpol.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// linear ramp between decoded samples, one step per output strobe
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module adpcmb_interpol (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    sample_en,
    input  adpcmb_pkg::pcm_sample_t sample,
    output logic signed [15:0]      pcm_out
);

    logic               strobe_d;                    // ramp one clock after strobe
    logic [15:0]        strobe_cnt;                  // strobes since last advance
    logic signed [15:0] pcm_last;                    // newest decoded sample
    logic signed [16:0] dx;
    logic [15:0]        dx_mag;
    logic               step_down;
    logic [15:0]        quotient;
    logic signed [17:0] ramp;
    logic signed [15:0] ramp_sat;

    assign dx     = {sample.value[15], sample.value} - {pcm_last[15], pcm_last};
    assign dx_mag = dx[16] ? (~dx[15:0] + 16'd1) : dx[15:0];

    always_comb begin
        if (step_down) ramp = {{2{pcm_out[15]}}, pcm_out} - {2'b00, quotient};
        else ramp = {{2{pcm_out[15]}}, pcm_out} + {2'b00, quotient};
        if (ramp > 18'sd32767) ramp_sat = 16'sh7fff;
        else if (ramp < -18'sd32768) ramp_sat = 16'sh8000;
        else ramp_sat = ramp[15:0];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            strobe_d   <= 1'b0;
            strobe_cnt <= '0;
            pcm_last   <= '0;
            pcm_out    <= '0;
            step_down  <= 1'b0;
        end else begin
            strobe_d <= sample_en;
            if (sample.valid) strobe_cnt <= {15'd0, sample_en};
            else if (sample_en && strobe_cnt != 16'hffff) strobe_cnt <= strobe_cnt + 1'b1;
            if (sample.valid) begin
                pcm_last  <= sample.value;
                pcm_out   <= pcm_last;               // restart ramp from older sample
                step_down <= dx[16];
            end else if (strobe_d) begin
                pcm_out <= ramp_sat;
            end
        end
    end

    // |new - old| / strobes, in use from the next strobe on
    adpcmb_divider divider_inst (
        .clk      (clk),
        .reset    (reset),
        .start    (sample.valid),
        .dividend (dx_mag),
        .divisor  (strobe_cnt),
        .quotient (quotient)
    );

endmodule

//--- design/adpcmb_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ADPCM-B playback core, wishbone codes in and interpolated PCM out
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module adpcmb_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                sample_en,
    input  adpcmb_pkg::wb_req_t req,
    output adpcmb_pkg::wb_rsp_t rsp,
    output logic signed [15:0]  pcm_out
);
    import adpcmb_pkg::*;

    logic [7:0]  head;
    logic        empty;
    logic [15:0] delta_n;
    logic        pop;
    logic        underrun_set;
    pcm_sample_t sample;

    adpcmb_wb_buffer wb_buffer_inst (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .rsp          (rsp),
        .pop          (pop),
        .underrun_set (underrun_set),
        .head         (head),
        .empty        (empty),
        .delta_n      (delta_n)
    );

    adpcmb_decoder decoder_inst (
        .clk          (clk),
        .reset        (reset),
        .sample_en    (sample_en),
        .head         (head),
        .empty        (empty),
        .delta_n      (delta_n),
        .pop          (pop),
        .underrun_set (underrun_set),
        .sample       (sample)
    );

    adpcmb_interpol interpol_inst (
        .clk       (clk),
        .reset     (reset),
        .sample_en (sample_en),
        .sample    (sample),
        .pcm_out   (pcm_out)
    );

endmodule

//--- verif/adpcmb_chk.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// wishbone handshake and FIFO bound checks, bound into the code buffer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module adpcmb_chk (
    input logic                                    clk,
    input logic                                    reset,
    input adpcmb_pkg::wb_req_t                     req,
    input adpcmb_pkg::wb_rsp_t                     rsp,
    input logic [$clog2(adpcmb_pkg::FIFO_DEPTH):0] count,
    input logic                                    pop,
    input logic                                    empty
);
    timeunit 1ns;
    timeprecision 100ps;
    import adpcmb_pkg::*;

    int fail_count = 0;                              // summed into the closing line

    ack_one_cycle: assert property (@(posedge clk) disable iff (reset) rsp.ack |=> !rsp.ack)
        else begin
            fail_count++;
            $error("ack held for more than one clock");
        end

    // stb may drop in the ack clock, so look at the request one clock back
    ack_needs_stb: assert property (@(posedge clk) disable iff (reset)
        rsp.ack |-> $past(req.cyc && req.stb))
        else begin
            fail_count++;
            $error("ack without a request");
        end

    // fill level never passes the FIFO depth
    no_overflow: assert property (@(posedge clk) disable iff (reset) count <= FIFO_DEPTH)
        else begin
            fail_count++;
            $error("code FIFO overflow");
        end

    no_underflow: assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
        else begin
            fail_count++;
            $error("code FIFO underflow");
        end

endmodule

//--- verif/adpcmb_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed tests of the ADPCM-B core against a behavioural model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module adpcmb_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import adpcmb_pkg::*;

    localparam int STROBE_CLKS  = 32;
    localparam int NUM_STROBES  = 140;               // 4 + 4 + 64 + 64 + 4
    localparam int NUM_WB       = 50;                // bus accesses, rounded up
    localparam int WB_LIMIT     = 1000;              // clocks one access may wait
    localparam int TIMEOUT_CLKS = NUM_STROBES * STROBE_CLKS + NUM_WB * 4 + 500;

    logic               clk = 1'b0;
    logic               reset;
    logic               sample_en;
    wb_req_t            req;
    wb_rsp_t            rsp;
    logic signed [15:0] pcm_out;
    int                 value_errors = 0;
    int                 other_errors = 0;
    int                 cycle_count = 0;
    // model state, decoder then interpolator
    int                 m_acc, m_delta, m_smp, m_step;
    int                 m_last, m_out, m_q, m_cnt;
    logic               m_nib_sel, m_down;
    logic [7:0]         m_fifo [$];                  // bytes written, not yet fully played

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > TIMEOUT_CLKS) begin
            $display("Timeout: run still busy after %0d clocks", TIMEOUT_CLKS);
            $display("Some tests failed");
            $finish;
        end
    end

    adpcmb_top adpcmb_top_inst (
        .clk       (clk),
        .reset     (reset),
        .sample_en (sample_en),
        .req       (req),
        .rsp       (rsp),
        .pcm_out   (pcm_out)
    );

    bind adpcmb_wb_buffer adpcmb_chk chk_inst (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .rsp   (rsp),
        .count (count),
        .pop   (pop),
        .empty (empty)
    );

    task automatic check_rsp(input wb_rsp_t got, input wb_rsp_t exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("Fail at %0t: %s, got ack %b dat %h, expected ack %b dat %h",
                     $time, what, got.ack, got.dat, exp.ack, exp.dat);
        end
    endtask

    task automatic check_pcm(input logic signed [15:0] got, input logic signed [15:0] exp,
                             input string what);
        if (got !== exp) begin
            value_errors++;
            $display("Fail at %0t: %s, pcm_out %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    function automatic int sat16(input int v);
        if (v > 32767) return 32767;
        if (v < -32768) return -32768;
        return v;
    endfunction

    function automatic int mult_of(input int mag);   // step growth in 64ths
        case (mag)
            4:       return 77;
            5:       return 102;
            6:       return 128;
            7:       return 153;
            default: return 57;
        endcase
    endfunction

    task automatic model_strobe(output logic adv);
        int sum;
        int nib;
        int diff;
        adv   = 1'b0;
        sum   = m_acc + m_delta;
        m_acc = sum % 65536;
        if (sum > 65535 && m_fifo.size() > 0) begin  // carry with data, else underrun
            nib = m_nib_sel ? int'(m_fifo[0][3:0]) : int'(m_fifo[0][7:4]);
            if (m_nib_sel) m_fifo.delete(0);
            m_nib_sel = ~m_nib_sel;
            diff   = (2 * (nib % 8) + 1) * m_step / 8;
            m_smp  = sat16((nib >= 8) ? m_smp - diff : m_smp + diff);
            m_step = m_step * mult_of(nib % 8) / 64;
            if (m_step < int'(STEP_MIN)) m_step = int'(STEP_MIN);
            if (m_step > int'(STEP_MAX)) m_step = int'(STEP_MAX);
            adv = 1'b1;
        end
        if (m_cnt < 65535) m_cnt++;
        if (adv) begin
            diff   = m_smp - m_last;
            m_out  = m_last;                         // ramp restarts at the older sample
            m_down = (diff < 0);
            m_q    = (m_cnt == 0) ? 0 : ((diff < 0) ? -diff : diff) / m_cnt;
            m_last = m_smp;
            m_cnt  = 0;
        end else begin
            m_out = sat16(m_down ? m_out - m_q : m_out + m_q);
        end
    endtask

    task automatic run_strobe(input string what);
        logic adv;
        sample_en = 1'b1;
        model_strobe(adv);
        @(negedge clk);
        sample_en = 1'b0;
        repeat (STROBE_CLKS - 1) @(negedge clk);     // pcm_out settled long before
        check_pcm(pcm_out, 16'(m_out),
                  $sformatf("%s, %s strobe", what, adv ? "advance" : "ramp"));
    endtask

    task automatic wb_access(input logic we, input logic [1:0] adr, input logic [15:0] dat,
                             output wb_rsp_t got, output int waited);
        req    = {1'b1, 1'b1, we, adr, dat};
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!rsp.ack && waited < WB_LIMIT);
        got = rsp;
        req = '0;                                    // stb drops once ack is seen
        if (!got.ack) begin
            other_errors++;
            $display("wishbone access to address %0d was never acknowledged", adr);
        end
    endtask

    task automatic write_reg(input logic [1:0] adr, input logic [15:0] dat);
        wb_rsp_t got;
        int      waited;
        wb_access(1'b1, adr, dat, got, waited);
        if (adr == ADDR_CODES) m_fifo.push_back(dat[7:0]);
        if (adr == ADDR_DELTA) m_delta = dat;
    endtask

    task automatic read_status(input logic [15:0] exp_dat, input string what);
        wb_rsp_t got;
        int      waited;
        wb_access(1'b0, ADDR_STATUS, 16'd0, got, waited);
        check_rsp(got, {1'b1, exp_dat}, what);
    endtask

    task automatic test_reset_state();
        read_status(16'h0000, "status after reset");
        repeat (4) run_strobe("pcm_out with delta-N 0");
    endtask

    task automatic test_backpressure();
        wb_rsp_t    got;
        int         waited;
        logic [7:0] extra;
        for (int i = 0; i < FIFO_DEPTH; i++) write_reg(ADDR_CODES, 16'($urandom % 256));
        read_status(16'd16, "fill level of a full FIFO");
        write_reg(ADDR_DELTA, 16'd32768);            // advance on every second strobe
        extra = 8'($urandom % 256);
        m_fifo.push_back(extra);
        fork
            wb_access(1'b1, ADDR_CODES, {8'd0, extra}, got, waited);
            repeat (4) run_strobe("pcm_out while a write is held off");
        join
        if (waited < 3 * STROBE_CLKS) begin          // first pop follows the 4th strobe
            other_errors++;
            $display("write to a full FIFO was acknowledged after %0d clocks", waited);
        end
        read_status(16'd16, "fill level after one pop and the held write");
    endtask

    task automatic test_playback();
        repeat (64) run_strobe("random playback");
    endtask

    task automatic test_saturation();
        repeat (8) write_reg(ADDR_CODES, 16'h0077);  // largest positive steps
        repeat (32) run_strobe("rising to full scale");
        check_pcm(pcm_out, 16'sh7fff, "positive full scale");
        repeat (8) write_reg(ADDR_CODES, 16'h00ff);
        repeat (32) run_strobe("falling to full scale");
        check_pcm(pcm_out, 16'sh8000, "negative full scale");
    endtask

    task automatic test_underrun();
        read_status(16'h0000, "status with an empty FIFO");
        repeat (4) run_strobe("pcm_out during underrun");
        check_pcm(pcm_out, 16'sh8000, "output held during underrun");
        read_status(16'h0100, "underrun flag set");
        read_status(16'h0000, "underrun flag cleared by the status read");
    endtask

    initial begin
        void'($urandom(32'h786a));
        reset     = 1'b1;
        sample_en = 1'b0;
        req       = '0;
        m_acc     = 0;
        m_delta   = 0;
        m_smp     = 0;
        m_step    = int'(STEP_INIT);
        m_last    = 0;
        m_out     = 0;
        m_q       = 0;
        m_cnt     = 0;
        m_nib_sel = 1'b0;
        m_down    = 1'b0;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        test_reset_state();
        test_backpressure();
        test_playback();
        test_saturation();
        test_underrun();
        other_errors += adpcmb_top_inst.wb_buffer_inst.chk_inst.fail_count;
        $display("Errors: %0d wrong values, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
design/adpcmb_pkg.sv
design/adpcmb_wb_buffer.sv
design/adpcmb_decoder.sv
design/adpcmb_divider.sv
design/adpcmb_interpol.sv
design/adpcmb_top.sv
verif/adpcmb_chk.sv
verif/adpcmb_tb.sv

//--- Makefile
SRCS := $(shell cat verilog.f)

obj_dir/Vadpcmb_tb: verilog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module adpcmb_tb -f verilog.f

run: obj_dir/Vadpcmb_tb
	@out="$$(./obj_dir/Vadpcmb_tb)"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

.PHONY: run clean
